// ==== src/bus_macros.svh ====
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// RAM covers 0x0000 up to the peripheral window at 0x7FF0
`define RAM_ADDR_BITS 15

// display registers, four byte slots with the last one vacant
`define HEX_BASE 16'h7FF0

// UART data at offset 0 and status at offset 1
`define UART_BASE 16'h7FF8

`define IRQ_BASE 16'h7FFC

// boot ROM occupies the top page, including the CPU vectors
`define ROM_BASE 16'hFF00
`define ROM_ADDR_BITS 8

`define UART_CLKS_PER_BIT 16

`endif

// ==== src/bus_pkg.sv ====
package bus_pkg;

    // a CPU address
    typedef logic [15:0] addr_t;

    // one byte on the data bus
    typedef logic [7:0] data_t;

    // block chosen by the address decoder
    typedef enum logic [2:0] {
        region_ram  = 3'd0,
        region_rom  = 3'd1,
        region_hex  = 3'd2,
        region_uart = 3'd3,
        region_irq  = 3'd4,
        region_none = 3'd5
    } region_e;

endpackage

// ==== src/periph_bus_if.sv ====
interface periph_bus_if;
    import bus_pkg::*;

    logic       cs;
    logic       we;
    logic [1:0] reg_addr;
    data_t      wdata;
    data_t      rdata;

    // the decoder side presents the access
    modport host (output cs, we, reg_addr, wdata, input rdata);

    // a peripheral registers rdata on the edge of a read
    modport periph (input cs, we, reg_addr, wdata, output rdata);

endinterface

// ==== src/bus_decoder.sv ====
`include "bus_macros.svh"

module bus_decoder (
    input  logic           clk,
    input  logic           rst,
    input  bus_pkg::addr_t addr,
    input  logic           rwb,
    input  bus_pkg::data_t wdata,
    output logic           ram_we,
    input  bus_pkg::data_t ram_q,
    input  bus_pkg::data_t rom_q,
    periph_bus_if.host     hex_bus,
    periph_bus_if.host     uart_bus,
    periph_bus_if.host     irq_bus,
    output bus_pkg::data_t rdata
);
    import bus_pkg::*;

    localparam addr_t hex_base  = `HEX_BASE;
    localparam addr_t uart_base = `UART_BASE;
    localparam addr_t irq_base  = `IRQ_BASE;
    localparam addr_t rom_base  = `ROM_BASE;

    region_e region;
    region_e region_q;
    logic    slot_valid;
    logic    slot_valid_q;

    // peripheral slots are checked first so they take priority over RAM
    always_comb begin
        region     = region_none;
        slot_valid = 1'b0;
        if (addr[15:2] == hex_base[15:2]) begin
            region     = region_hex;
            slot_valid = addr[1:0] != 2'd3;
        end else if (addr[15:2] == uart_base[15:2]) begin
            region     = region_uart;
            slot_valid = ~addr[1];
        end else if (addr[15:2] == irq_base[15:2]) begin
            region     = region_irq;
            slot_valid = addr[1:0] == 2'd0;
        end else if (addr < hex_base) begin
            region     = region_ram;
            slot_valid = 1'b1;
        end else if (addr[15:8] == rom_base[15:8]) begin
            region     = region_rom;
            slot_valid = 1'b1;
        end
    end

    assign ram_we = (region == region_ram) && !rwb;

    assign hex_bus.cs       = (region == region_hex) && slot_valid;
    assign hex_bus.we       = !rwb;
    assign hex_bus.reg_addr = addr[1:0];
    assign hex_bus.wdata    = wdata;

    assign uart_bus.cs       = (region == region_uart) && slot_valid;
    assign uart_bus.we       = !rwb;
    assign uart_bus.reg_addr = addr[1:0];
    assign uart_bus.wdata    = wdata;

    assign irq_bus.cs       = (region == region_irq) && slot_valid;
    assign irq_bus.we       = !rwb;
    assign irq_bus.reg_addr = addr[1:0];
    assign irq_bus.wdata    = wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            region_q     <= region_none;
            slot_valid_q <= 1'b0;
        end else begin
            region_q     <= region;
            slot_valid_q <= slot_valid;
        end
    end

    // every block delivers its byte one cycle after the address
    always_comb begin
        rdata = '0;
        if (slot_valid_q) begin
            case (region_q)
                region_ram:  rdata = ram_q;
                region_rom:  rdata = rom_q;
                region_hex:  rdata = hex_bus.rdata;
                region_uart: rdata = uart_bus.rdata;
                region_irq:  rdata = irq_bus.rdata;
                default:     rdata = '0;
            endcase
        end
    end

endmodule

// ==== src/ram.sv ====
`include "bus_macros.svh"

module ram (
    input  logic                      clk,
    input  logic [`RAM_ADDR_BITS-1:0] addr,
    input  logic                      we,
    input  bus_pkg::data_t            wdata,
    output bus_pkg::data_t            q
);
    import bus_pkg::*;

    localparam int depth = 1 << `RAM_ADDR_BITS;

    data_t mem [depth];

    // write-first, a write returns the byte it stores
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            q         <= wdata;
        end else begin
            q <= mem[addr];
        end
    end

endmodule

// ==== src/boot_rom.sv ====
`include "bus_macros.svh"

module boot_rom (
    input  logic                      clk,
    input  logic [`ROM_ADDR_BITS-1:0] addr,
    output bus_pkg::data_t            q
);
    import bus_pkg::*;

    localparam int depth = 1 << `ROM_ADDR_BITS;

    data_t mem [depth];

    initial begin
        $readmemh("rom.hex", mem);
    end

    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

endmodule

// ==== src/seven_seg.sv ====
module seven_seg (
    input  logic        clk,
    input  logic        rst,
    periph_bus_if.periph bus,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1,
    output logic [6:0]  hex2,
    output logic [6:0]  hex3,
    output logic [6:0]  hex4,
    output logic [6:0]  hex5
);
    import bus_pkg::*;

    data_t digit_reg [3];

    // active-low segments with segment a in bit 0
    function automatic logic [6:0] seg_encode(input logic [3:0] nibble);
        logic [6:0] seg;
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                digit_reg[i] <= '0;
            end
        end else if (bus.cs && bus.we && bus.reg_addr != 2'd3) begin
            digit_reg[bus.reg_addr] <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cs && !bus.we) begin
            bus.rdata <= (bus.reg_addr != 2'd3) ? digit_reg[bus.reg_addr] : '0;
        end
    end

    // low nibble on the even digit, high nibble on the odd one
    assign hex0 = seg_encode(digit_reg[0][3:0]);
    assign hex1 = seg_encode(digit_reg[0][7:4]);
    assign hex2 = seg_encode(digit_reg[1][3:0]);
    assign hex3 = seg_encode(digit_reg[1][7:4]);
    assign hex4 = seg_encode(digit_reg[2][3:0]);
    assign hex5 = seg_encode(digit_reg[2][7:4]);

endmodule

// ==== src/uart.sv ====
`include "bus_macros.svh"

module uart (
    input  logic        clk,
    input  logic        rst,
    periph_bus_if.periph bus,
    input  logic        rxd,
    output logic        txd
);
    import bus_pkg::*;

    localparam int clks_per_bit = `UART_CLKS_PER_BIT;
    localparam int cnt_bits     = $clog2(clks_per_bit);
    localparam logic [cnt_bits-1:0] bit_end  = cnt_bits'(clks_per_bit - 1);
    localparam logic [cnt_bits-1:0] bit_half = cnt_bits'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    logic                tx_busy;
    logic [9:0]          tx_shift;
    logic [cnt_bits-1:0] tx_clk_cnt;
    logic [3:0]          tx_bit_cnt;

    logic                rx_sync1;
    logic                rx_sync2;
    logic                rx_prev;
    rx_state_e           rx_state;
    logic [cnt_bits-1:0] rx_clk_cnt;
    logic [2:0]          rx_bit_cnt;
    data_t               rx_shift;
    data_t               rx_data_reg;
    logic                rx_valid;

    logic data_wr;
    logic data_rd;

    assign data_wr = bus.cs && bus.we && bus.reg_addr == 2'd0;
    assign data_rd = bus.cs && !bus.we && bus.reg_addr == 2'd0;

    // frame is start bit, eight data bits LSB first, stop bit
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy    <= 1'b0;
            tx_shift   <= '1;
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (data_wr) begin
                tx_busy    <= 1'b1;
                tx_shift   <= {1'b1, bus.wdata, 1'b0};
                tx_clk_cnt <= '0;
                tx_bit_cnt <= '0;
            end
        end else if (tx_clk_cnt == bit_end) begin
            tx_clk_cnt <= '0;
            tx_shift   <= {1'b1, tx_shift[9:1]};
            tx_bit_cnt <= tx_bit_cnt + 4'd1;
            if (tx_bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end
        end else begin
            tx_clk_cnt <= tx_clk_cnt + 1'b1;
        end
    end

    assign txd = tx_busy ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync1 <= 1'b1;
            rx_sync2 <= 1'b1;
            rx_prev  <= 1'b1;
        end else begin
            rx_sync1 <= rxd;
            rx_sync2 <= rx_sync1;
            rx_prev  <= rx_sync2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state   <= rx_idle;
            rx_clk_cnt <= '0;
            rx_bit_cnt <= '0;
            rx_valid   <= 1'b0;
        end else begin
            // reading the data register consumes the byte
            if (data_rd) begin
                rx_valid <= 1'b0;
            end
            case (rx_state)
                rx_idle: begin
                    if (rx_prev && !rx_sync2) begin
                        rx_state   <= rx_start;
                        rx_clk_cnt <= '0;
                    end
                end
                rx_start: begin
                    if (rx_clk_cnt == bit_half) begin
                        rx_clk_cnt <= '0;
                        rx_bit_cnt <= '0;
                        // a glitch that is gone by mid-bit is not a start bit
                        rx_state   <= rx_sync2 ? rx_idle : rx_data;
                    end else begin
                        rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (rx_clk_cnt == bit_end) begin
                        rx_clk_cnt <= '0;
                        rx_shift   <= {rx_sync2, rx_shift[7:1]};
                        rx_bit_cnt <= rx_bit_cnt + 3'd1;
                        if (rx_bit_cnt == 3'd7) begin
                            rx_state <= rx_stop;
                        end
                    end else begin
                        rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_clk_cnt == bit_end) begin
                        rx_clk_cnt <= '0;
                        rx_state   <= rx_idle;
                        if (rx_sync2) begin
                            rx_data_reg <= rx_shift;
                            rx_valid    <= 1'b1;
                        end
                    end else begin
                        rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cs && !bus.we) begin
            case (bus.reg_addr)
                2'd0:    bus.rdata <= rx_data_reg;
                2'd1:    bus.rdata <= {6'b0, rx_valid, tx_busy};
                default: bus.rdata <= '0;
            endcase
        end
    end

endmodule

// ==== src/irq_ctrl.sv ====
module irq_ctrl (
    input  logic        clk,
    input  logic        rst,
    periph_bus_if.periph bus,
    input  logic        button_n,
    output logic        irqb
);
    import bus_pkg::*;

    data_t flags;
    data_t flags_next;

    always_comb begin
        flags_next = flags;
        if (bus.cs && bus.we && bus.reg_addr == 2'd0) begin
            flags_next = flags & bus.wdata;
        end
        // the button set overrides a clear in the same cycle
        if (!button_n) begin
            flags_next[0] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cs && !bus.we) begin
            bus.rdata <= (bus.reg_addr == 2'd0) ? flags : '0;
        end
    end

    assign irqb = ~|flags;

endmodule

// ==== src/super6502_top.sv ====
`include "bus_macros.svh"

module super6502_top (
    input  logic           clk,
    input  logic           rst,
    input  bus_pkg::addr_t cpu_addr,
    input  bus_pkg::data_t cpu_data_in,
    output bus_pkg::data_t cpu_data_out,
    input  logic           cpu_rwb,
    input  logic           button_n,
    output logic           cpu_irqb,
    output logic           cpu_phi2,
    output logic [6:0]     hex0,
    output logic [6:0]     hex1,
    output logic [6:0]     hex2,
    output logic [6:0]     hex3,
    output logic [6:0]     hex4,
    output logic [6:0]     hex5,
    input  logic           uart_rxd,
    output logic           uart_txd
);
    import bus_pkg::*;

    logic  ram_we;
    data_t ram_q;
    data_t rom_q;

    periph_bus_if hex_bus ();
    periph_bus_if uart_bus ();
    periph_bus_if irq_bus ();

    // the CPU clock runs at half the rate of clk
    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_phi2 <= 1'b0;
        end else begin
            cpu_phi2 <= ~cpu_phi2;
        end
    end

    bus_decoder bus_decoder_inst (
        .clk      (clk),
        .rst      (rst),
        .addr     (cpu_addr),
        .rwb      (cpu_rwb),
        .wdata    (cpu_data_in),
        .ram_we   (ram_we),
        .ram_q    (ram_q),
        .rom_q    (rom_q),
        .hex_bus  (hex_bus),
        .uart_bus (uart_bus),
        .irq_bus  (irq_bus),
        .rdata    (cpu_data_out)
    );

    ram ram_inst (
        .clk   (clk),
        .addr  (cpu_addr[`RAM_ADDR_BITS-1:0]),
        .we    (ram_we),
        .wdata (cpu_data_in),
        .q     (ram_q)
    );

    boot_rom boot_rom_inst (
        .clk  (clk),
        .addr (cpu_addr[`ROM_ADDR_BITS-1:0]),
        .q    (rom_q)
    );

    seven_seg seven_seg_inst (
        .clk  (clk),
        .rst  (rst),
        .bus  (hex_bus),
        .hex0 (hex0),
        .hex1 (hex1),
        .hex2 (hex2),
        .hex3 (hex3),
        .hex4 (hex4),
        .hex5 (hex5)
    );

    uart uart_inst (
        .clk (clk),
        .rst (rst),
        .bus (uart_bus),
        .rxd (uart_rxd),
        .txd (uart_txd)
    );

    irq_ctrl irq_ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .bus      (irq_bus),
        .button_n (button_n),
        .irqb     (cpu_irqb)
    );

endmodule

// ==== tests/tb_super6502.sv ====
`include "bus_macros.svh"

module tb_super6502;
    import bus_pkg::*;

    localparam int    cycle_limit = 6000;
    localparam int    poll_limit  = 12 * `UART_CLKS_PER_BIT;
    localparam addr_t idle_addr   = 16'h8000;
    localparam addr_t hex_base    = `HEX_BASE;
    localparam addr_t rom_base    = `ROM_BASE;
    localparam addr_t uart_data   = `UART_BASE;
    localparam addr_t uart_status = `UART_BASE + 16'd1;
    localparam addr_t irq_flags   = `IRQ_BASE;

    // active-low digit patterns, digit 0 in the lowest seven bits
    localparam logic [16*7-1:0] seg_table = {
        7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
        7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };

    logic       clk;
    logic       rst;
    addr_t      cpu_addr;
    data_t      cpu_data_in;
    data_t      cpu_data_out;
    logic       cpu_rwb;
    logic       button_n;
    logic       cpu_irqb;
    logic       cpu_phi2;
    logic [6:0] hex [6];
    logic       uart_line;

    logic [31:0] lfsr_state;
    logic        phi2_armed;
    int          cycle_count = 0;
    data_t       ram_model [1 << `RAM_ADDR_BITS];
    data_t       rom_model [1 << `ROM_ADDR_BITS];
    data_t       disp_val [3];
    addr_t       ram_addrs [$];

    // the UART transmitter feeds its own receiver
    super6502_top super6502_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_data_out (cpu_data_out),
        .cpu_rwb      (cpu_rwb),
        .button_n     (button_n),
        .cpu_irqb     (cpu_irqb),
        .cpu_phi2     (cpu_phi2),
        .hex0         (hex[0]),
        .hex1         (hex[1]),
        .hex2         (hex[2]),
        .hex3         (hex[3]),
        .hex4         (hex[4]),
        .hex5         (hex[5]),
        .uart_rxd     (uart_line),
        .uart_txd     (uart_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic value_mismatch(input string name, input logic [7:0] expected,
                                  input logic [7:0] actual);
        $display("** FAIL **");
        $display("[ERROR] t=%0t %s expected 0x%h actual 0x%h", $time, name, expected, actual);
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic abort_run(input string reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    // phi2 runs at half the clk rate once reset is over
    phi2_toggle: assert property (@(negedge clk) phi2_armed |-> cpu_phi2 != $past(cpu_phi2))
        else abort_run("cpu_phi2 did not invert within one clk cycle");

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t data);
        cpu_addr    = addr;
        cpu_data_in = data;
        cpu_rwb     = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_read_value(input addr_t addr, output data_t value);
        cpu_addr = addr;
        cpu_rwb  = 1'b1;
        @(negedge clk);
        value = cpu_data_out;
    endtask

    // the byte for this address is on cpu_data_out until the next rising edge
    task automatic bus_read(input addr_t addr, input data_t expected);
        cpu_addr = addr;
        cpu_rwb  = 1'b1;
        @(negedge clk);
        assert (cpu_data_out === expected)
            else value_mismatch($sformatf("cpu_data_out at 0x%h", addr), expected, cpu_data_out);
    endtask

    task automatic bus_idle();
        cpu_addr = idle_addr;
        cpu_rwb  = 1'b1;
        @(negedge clk);
    endtask

    task automatic check_display();
        logic [3:0] nibble;
        logic [6:0] expected;
        for (int i = 0; i < 6; i++) begin
            nibble   = disp_val[i / 2][4 * (i % 2) +: 4];
            expected = seg_table[7 * nibble +: 7];
            assert (hex[i] === expected)
                else value_mismatch($sformatf("hex%0d", i), {1'b0, expected}, {1'b0, hex[i]});
        end
    endtask

    task automatic check_reset_state();
        assert (cpu_phi2 === 1'b0) else value_mismatch("cpu_phi2", 8'h00, {7'b0, cpu_phi2});
        assert (cpu_irqb === 1'b1) else value_mismatch("cpu_irqb", 8'h01, {7'b0, cpu_irqb});
        assert (uart_line === 1'b1) else value_mismatch("uart_txd", 8'h01, {7'b0, uart_line});
        check_display();
    endtask

    task automatic ram_test();
        logic [31:0] bits;
        addr_t       addr;
        data_t       data;
        for (int i = 0; i < 64; i++) begin
            addr = 16'hFFFF;
            while (addr >= hex_base) begin
                take_bits(15, bits);
                addr = bits[15:0];
            end
            take_bits(8, bits);
            data = bits[7:0];
            bus_write(addr, data);
            ram_model[addr[`RAM_ADDR_BITS-1:0]] = data;
            ram_addrs.push_back(addr);
            if (i % 8 == 0) begin
                bus_read(addr, data);
            end
        end
        foreach (ram_addrs[i]) begin
            bus_read(ram_addrs[i], ram_model[ram_addrs[i][`RAM_ADDR_BITS-1:0]]);
        end
    endtask

    task automatic decode_test();
        logic [31:0] bits;
        addr_t       addr;
        addr_t       vacant [6];
        vacant = '{16'h7FF3, 16'h7FFA, 16'h7FFB, 16'h7FFD, 16'h7FFE, 16'h7FFF};
        for (int i = 0; i < 16; i++) begin
            take_bits(8, bits);
            bus_read(rom_base | bits[15:0], rom_model[bits[7:0]]);
        end
        for (int i = 0; i < 8; i++) begin
            addr = 16'hFFFF;
            while (addr >= rom_base) begin
                take_bits(15, bits);
                addr = idle_addr | bits[15:0];
            end
            bus_read(addr, 8'h00);
        end
        // the upper half aliases RAM on the low address bits, so RAM must not change
        for (int i = 0; i < 8; i++) begin
            addr = idle_addr | ram_addrs[i];
            if (addr < rom_base) begin
                bus_write(addr, ~ram_model[ram_addrs[i][`RAM_ADDR_BITS-1:0]]);
                bus_read(addr, 8'h00);
                bus_read(ram_addrs[i], ram_model[ram_addrs[i][`RAM_ADDR_BITS-1:0]]);
            end
        end
        foreach (vacant[i]) begin
            bus_write(vacant[i], 8'hFF);
        end
        foreach (vacant[i]) begin
            bus_read(vacant[i], 8'h00);
        end
        bus_idle();
        check_display();
    endtask

    task automatic display_test();
        logic [31:0] bits;
        for (int n = 0; n < 3; n++) begin
            take_bits(8, bits);
            disp_val[n] = bits[7:0];
            bus_write(hex_base + addr_t'(n), disp_val[n]);
        end
        check_display();
        for (int n = 0; n < 3; n++) begin
            bus_read(hex_base + addr_t'(n), disp_val[n]);
        end
    endtask

    task automatic uart_loopback(input data_t data);
        data_t status;
        int    polls;
        polls = 0;
        bus_write(uart_data, data);
        bus_read(uart_status, 8'h01);
        status = 8'h01;
        while (!status[1]) begin
            bus_read_value(uart_status, status);
            polls++;
            if (polls > poll_limit) begin
                abort_run("the UART receiver never reported the looped-back byte");
            end
        end
        // rx_valid rises mid stop bit, so the transmitter is still finishing
        while (status == 8'h03) begin
            bus_read_value(uart_status, status);
            polls++;
            if (polls > poll_limit) begin
                abort_run("the UART transmitter stayed busy after the frame");
            end
        end
        assert (status === 8'h02) else value_mismatch("uart status", 8'h02, status);
        bus_read(uart_data, data);
        bus_read(uart_status, 8'h00);
    endtask

    task automatic irq_test();
        button_n = 1'b0;
        bus_idle();
        bus_idle();
        button_n = 1'b1;
        assert (cpu_irqb === 1'b0) else value_mismatch("cpu_irqb", 8'h00, {7'b0, cpu_irqb});
        bus_read(irq_flags, 8'h01);
        // the vacant slots beside the flag register must not clear a pending flag
        for (int i = 1; i < 4; i++) begin
            bus_write(irq_flags + addr_t'(i), 8'h00);
        end
        bus_read(irq_flags, 8'h01);
        bus_write(irq_flags, 8'hFE);
        assert (cpu_irqb === 1'b1) else value_mismatch("cpu_irqb", 8'h01, {7'b0, cpu_irqb});
        bus_read(irq_flags, 8'h00);
    endtask

    initial begin
        logic [31:0] bits;
        rst         = 1'b1;
        cpu_addr    = idle_addr;
        cpu_data_in = 8'h00;
        cpu_rwb     = 1'b1;
        button_n    = 1'b1;
        phi2_armed  = 1'b0;
        lfsr_state  = 32'ha7d9_b8c9;
        disp_val    = '{default: 8'h00};
        $readmemh("rom.hex", rom_model);

        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        phi2_armed = 1'b1;

        ram_test();
        decode_test();
        display_test();
        for (int i = 0; i < 2; i++) begin
            take_bits(8, bits);
            uart_loopback(bits[7:0]);
        end
        irq_test();
        bus_idle();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
src/bus_pkg.sv
src/periph_bus_if.sv
src/bus_decoder.sv
src/ram.sv
src/boot_rom.sv
src/seven_seg.sv
src/uart.sv
src/irq_ctrl.sv
src/super6502_top.sv
tests/tb_super6502.sv

// ==== Bender.yml ====
package:
  name: super6502

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/bus_pkg.sv
      - src/periph_bus_if.sv
      - src/bus_decoder.sv
      - src/ram.sv
      - src/boot_rom.sv
      - src/seven_seg.sv
      - src/uart.sv
      - src/irq_ctrl.sv
      - src/super6502_top.sv
      - target: test
        files:
          - tests/tb_super6502.sv

// ==== rom.hex ====
// boot ROM bytes for 0xFF00 to 0xFFFF, 16 bytes per line, each line starts at offset 16*n
a5 a4 a7 a6 a1 a0 a3 a2 ad ac af ae a9 a8 ab aa
b5 b4 b7 b6 b1 b0 b3 b2 bd bc bf be b9 b8 bb ba
85 84 87 86 81 80 83 82 8d 8c 8f 8e 89 88 8b 8a
95 94 97 96 91 90 93 92 9d 9c 9f 9e 99 98 9b 9a
e5 e4 e7 e6 e1 e0 e3 e2 ed ec ef ee e9 e8 eb ea
f5 f4 f7 f6 f1 f0 f3 f2 fd fc ff fe f9 f8 fb fa
c5 c4 c7 c6 c1 c0 c3 c2 cd cc cf ce c9 c8 cb ca
d5 d4 d7 d6 d1 d0 d3 d2 dd dc df de d9 d8 db da
25 24 27 26 21 20 23 22 2d 2c 2f 2e 29 28 2b 2a
35 34 37 36 31 30 33 32 3d 3c 3f 3e 39 38 3b 3a
05 04 07 06 01 00 03 02 0d 0c 0f 0e 09 08 0b 0a
15 14 17 16 11 10 13 12 1d 1c 1f 1e 19 18 1b 1a
65 64 67 66 61 60 63 62 6d 6c 6f 6e 69 68 6b 6a
75 74 77 76 71 70 73 72 7d 7c 7f 7e 79 78 7b 7a
45 44 47 46 41 40 43 42 4d 4c 4f 4e 49 48 4b 4a
55 54 57 56 51 50 53 52 5d 5c 5f 5e 59 58 5b 5a
